// File: logic/synctimer_pkg.sv
// widths, fixed-point positions and value types of the timer adjuster
`default_nettype none

package synctimer_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned TIMER_WIDTH = 32; // local and corrected timer
    localparam int unsigned CYCLE_WIDTH = 32; // raw cycle counter
    localparam int unsigned ERROR_WIDTH = 32; // integer part of errors and limits

    // --------------------
    // fixed-point positions
    // --------------------

    // fraction bits appended to time errors
    localparam int unsigned ERROR_Q = 8;

    // fraction bits of the cycle estimate, doubles as cycle filter gain (1/2^N)
    localparam int unsigned CYCLE_Q = 6;

    // --------------------
    // value types
    // --------------------

    // timer value, wraps freely
    typedef logic [TIMER_WIDTH-1:0] time_t;

    // raw cycles between two corrections
    typedef logic [CYCLE_WIDTH-1:0] count_t;

    // smoothed cycles per correction period, CYCLE_Q fraction bits
    typedef logic [CYCLE_WIDTH+CYCLE_Q-1:0] cycle_t;

    // phase/period error and adjustment, ERROR_Q fraction bits
    typedef logic signed [ERROR_WIDTH+ERROR_Q-1:0] error_t;

    // adjustment limit, integer cycles
    typedef logic signed [ERROR_WIDTH-1:0] limit_t;

endpackage

`default_nettype wire

// File: logic/lpf_update.sv
// first-order low-pass filter holding one estimate and its valid flag
`timescale 1ns/1ps
`default_nettype none

module lpf_update #(
    parameter type         value_t = logic [31:0],
    parameter int unsigned GAIN    = 6             // update weight 1/2^GAIN
) (
    input  logic   clk,
    input  logic   reset,

    input  logic   clear,       // drop the estimate, next observation loads directly
    input  logic   update,
    input  value_t observe,
    input  logic   observe_en,

    output value_t estimate,
    output logic   estimate_en
);

    value_t predict_gain; // held estimate minus its share
    value_t observe_gain;
    logic   load;

    // the held estimate is the prediction
    always_comb begin
        predict_gain = estimate - (estimate >>> GAIN);
        observe_gain = observe >>> GAIN;
        load         = update && observe_en;
    end

    // --------------------
    // valid flag
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            estimate_en <= 1'b0;
        end else if (clear) begin
            estimate_en <= 1'b0;
        end else if (load) begin
            estimate_en <= 1'b1;
        end
    end

    // --------------------
    // estimate
    // --------------------
    always_ff @(posedge clk) begin
        if (load) begin
            if (estimate_en && !clear) begin
                estimate <= predict_gain + observe_gain;
            end else begin
                estimate <= observe; // first observation taken as is
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/cycle_estimator.sv
// local cycle counter between corrections and smoothed cycles-per-period estimate
`timescale 1ns/1ps
`default_nettype none

module cycle_estimator (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  correct_valid,

    output synctimer_pkg::cycle_t request_cycle
);

    import synctimer_pkg::*;

    count_t count;
    logic   count_enable;  // set by the first strobe
    logic   count_valid;   // strobe that closes a full period

    count_t count_hold;    // raw count of the period just closed
    logic   hold_strobe;
    cycle_t observe;
    logic   update;

    cycle_t estimate;
    logic   estimate_en;

    // --------------------
    // cycle counter
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            count        <= '0;
            count_enable <= 1'b0;
        end else begin
            count <= count + count_t'(1);
            if (correct_valid) begin
                count        <= count_t'(1); // strobe cycle counts as the first
                count_enable <= 1'b1;
            end
        end
    end

    always_comb count_valid = correct_valid & count_enable;

    // --------------------
    // observation pipeline
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_strobe <= 1'b0;
            update      <= 1'b0;
        end else begin
            hold_strobe <= count_valid;
            update      <= hold_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (count_valid) begin
            count_hold <= count;
        end
        if (hold_strobe) begin
            observe <= cycle_t'(count_hold) <<< CYCLE_Q; // to fixed point
        end
    end

    // gain tied to the fraction width
    lpf_update #(
        .value_t (cycle_t),
        .GAIN    (CYCLE_Q)
    ) u_cycle_lpf (
        .clk         (clk),
        .reset       (reset),
        .clear       (1'b0),
        .update      (update),
        .observe     (observe),
        .observe_en  (1'b1),          // every update carries a full period
        .estimate    (estimate),
        .estimate_en (estimate_en)
    );

    // reads zero until the first period has been measured
    always_comb request_cycle = estimate_en ? estimate : '0;

endmodule

`default_nettype wire

// File: logic/error_estimator.sv
// staged phase/period error estimation, adjustment sum and limiter
`timescale 1ns/1ps
`default_nettype none

module error_estimator #(
    parameter int unsigned PERIOD_GAIN = 6,
    parameter int unsigned PHASE_GAIN  = 6
) (
    input  logic                  clk,
    input  logic                  reset,

    input  synctimer_pkg::time_t  current_time,
    input  synctimer_pkg::time_t  correct_time,
    input  logic                  correct_valid,
    input  logic                  correct_renew,

    input  synctimer_pkg::limit_t param_adjust_min,
    input  synctimer_pkg::limit_t param_adjust_max,

    output synctimer_pkg::error_t request_value,
    output logic                  request_valid
);

    import synctimer_pkg::*;

    logic   [4:0] stage;         // one-hot walk through the pipeline
    logic         renew_strobe;

    error_t limit_min;
    error_t limit_max;
    time_t  time_gap;            // wraps, read as signed

    error_t time_diff;           // current difference
    logic   time_diff_en;
    error_t time_diff1;          // previous difference minus last adjustment
    logic   time_diff1_en;

    error_t observe_x;           // phase observation
    error_t observe_v;           // period observation
    logic   observe_v_en;

    logic   phase_clear;
    logic   filter_update;
    error_t estimate_x;
    logic   estimate_x_en;
    error_t estimate_v;
    logic   estimate_v_en;

    error_t adjust_total;
    error_t adjust_value;        // last issued adjustment

    always_comb begin
        limit_min    = error_t'(param_adjust_min) <<< ERROR_Q;
        limit_max    = error_t'(param_adjust_max) <<< ERROR_Q;
        time_gap     = correct_time - current_time;
        renew_strobe = correct_valid & correct_renew;
    end

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            stage         <= '0;
            time_diff_en  <= 1'b0;
            time_diff1_en <= 1'b0;
            observe_v_en  <= 1'b0;
            adjust_value  <= '0;
            request_valid <= 1'b0;
        end else begin
            stage         <= {stage[3:0], correct_valid};
            request_valid <= stage[4];

            if (correct_valid) begin
                time_diff_en  <= 1'b1;
                time_diff1_en <= time_diff_en;
                if (correct_renew) begin
                    time_diff1_en <= 1'b0;    // history dropped
                    adjust_value  <= '0;
                end
            end

            if (stage[0]) begin
                observe_v_en <= time_diff1_en;
            end

            // limiter
            if (stage[4]) begin
                if (adjust_total < limit_min) begin
                    adjust_value <= limit_min;
                end else if (adjust_total > limit_max) begin
                    adjust_value <= limit_max;
                end else begin
                    adjust_value <= adjust_total;
                end
            end
        end
    end

    // --------------------
    // datapath
    // --------------------
    always_ff @(posedge clk) begin
        // capture the difference
        if (correct_valid) begin
            time_diff  <= error_t'($signed(time_gap)) <<< ERROR_Q;
            time_diff1 <= time_diff - adjust_value;
            if (correct_renew) begin
                time_diff <= '0;
            end
        end

        // observe
        if (stage[0]) begin
            observe_x <= time_diff;
            observe_v <= time_diff - time_diff1;
        end

        // sum, raw difference until both estimates exist
        if (stage[3]) begin
            if (estimate_x_en && estimate_v_en) begin
                adjust_total <= estimate_x + estimate_v;
            end else begin
                adjust_total <= time_diff;
            end
        end
    end

    // phase has no prediction without a period estimate, restart it
    always_comb begin
        phase_clear   = renew_strobe | (stage[1] & ~estimate_v_en);
        filter_update = stage[2];
    end

    // --------------------
    // filters
    // --------------------
    lpf_update #(
        .value_t (error_t),
        .GAIN    (PHASE_GAIN)
    ) u_phase_lpf (
        .clk         (clk),
        .reset       (reset),
        .clear       (phase_clear),
        .update      (filter_update),
        .observe     (observe_x),
        .observe_en  (1'b1),          // a difference always exists here
        .estimate    (estimate_x),
        .estimate_en (estimate_x_en)
    );

    lpf_update #(
        .value_t (error_t),
        .GAIN    (PERIOD_GAIN)
    ) u_period_lpf (
        .clk         (clk),
        .reset       (reset),
        .clear       (renew_strobe),
        .update      (filter_update),
        .observe     (observe_v),
        .observe_en  (observe_v_en),
        .estimate    (estimate_v),
        .estimate_en (estimate_v_en)
    );

    always_comb request_value = adjust_value;

endmodule

`default_nettype wire

// File: logic/synctimer_adjuster_calc.sv
// top level of the timer adjuster error calculator, cycle and error estimators
`timescale 1ns/1ps
`default_nettype none

module synctimer_adjuster_calc #(
    parameter int unsigned PERIOD_GAIN = 6,  // period filter weight 1/2^N
    parameter int unsigned PHASE_GAIN  = 6   // phase filter weight 1/2^N
) (
    input  logic                  clk,
    input  logic                  reset,

    input  synctimer_pkg::time_t  current_time,

    input  logic                  correct_renew,
    input  synctimer_pkg::time_t  correct_time,
    input  logic                  correct_valid,

    input  synctimer_pkg::limit_t param_adjust_min,
    input  synctimer_pkg::limit_t param_adjust_max,

    output synctimer_pkg::error_t request_value,
    output synctimer_pkg::cycle_t request_cycle,
    output logic                  request_valid
);

    // --------------------
    // cycles per period
    // --------------------
    cycle_estimator u_cycle_estimator (
        .clk           (clk),
        .reset         (reset),
        .correct_valid (correct_valid),
        .request_cycle (request_cycle)
    );

    // --------------------
    // time error
    // --------------------
    error_estimator #(
        .PERIOD_GAIN (PERIOD_GAIN),
        .PHASE_GAIN  (PHASE_GAIN)
    ) u_error_estimator (
        .clk              (clk),
        .reset            (reset),
        .current_time     (current_time),
        .correct_time     (correct_time),
        .correct_valid    (correct_valid),
        .correct_renew    (correct_renew),
        .param_adjust_min (param_adjust_min),
        .param_adjust_max (param_adjust_max),
        .request_value    (request_value),
        .request_valid    (request_valid)
    );

endmodule

`default_nettype wire

// File: dv/synctimer_adjuster_sva.sv
// assertions on the request strobe and the adjustment limits, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module synctimer_adjuster_sva (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  request_valid,
    input  synctimer_pkg::error_t request_value,
    input  synctimer_pkg::limit_t param_adjust_min,
    input  synctimer_pkg::limit_t param_adjust_max
);

    import synctimer_pkg::*;

    error_t limit_lo;
    error_t limit_hi;
    int unsigned assert_failures = 0;  // failed assertions so far

    always_comb begin
        limit_lo = error_t'(param_adjust_min) <<< ERROR_Q;
        limit_hi = error_t'(param_adjust_max) <<< ERROR_Q;
    end

    // --------------------
    // strobe rules
    // --------------------
    valid_low_in_reset: assert property (@(posedge clk) reset |=> !request_valid)
        else begin
            $error("request_valid high while reset is applied");
            assert_failures++;
        end

    valid_single_cycle: assert property (@(posedge clk) disable iff (reset)
        request_valid |=> !request_valid)
        else begin
            $error("request_valid held for two cycles");
            assert_failures++;
        end

    value_in_limits: assert property (@(posedge clk) disable iff (reset)
        request_valid |-> (request_value >= limit_lo && request_value <= limit_hi))
        else begin
            $error("request_value outside the adjustment limits");
            assert_failures++;
        end

endmodule

`default_nettype wire

// File: dv/synctimer_adjuster_tb.sv
// timer adjuster testbench with clock, stimulus, reference rules, directed tests and summary
`timescale 1ns/1ps
`default_nettype none

module synctimer_adjuster_tb;

    import synctimer_pkg::*;

    localparam int ERR_PERIOD   = 10;
    localparam int RENEW_STEPS  = 4;
    localparam int TRACK_STEPS  = 8;
    localparam int LIMIT_STEPS  = 4;
    localparam int CYCLE_P1     = 12;
    localparam int CYCLE_P2     = 20;
    localparam int LIMIT_WIDE   = 100000;
    localparam int LIMIT_NARROW = 3000;
    localparam int WATCH_CYCLES = 16 + 20
        + (RENEW_STEPS + 2 * TRACK_STEPS + 2 * LIMIT_STEPS) * (ERR_PERIOD + 1)
        + 17 + 3 * CYCLE_P1 + 3 * CYCLE_P2
        + 200;                                  // margin

    logic   clk;
    logic   reset;
    time_t  current_time;
    time_t  correct_time;
    time_t  time_offset;                        // correct_time ahead of current_time
    logic   correct_valid;
    logic   correct_renew;
    limit_t param_adjust_min;
    limit_t param_adjust_max;
    error_t request_value;
    cycle_t request_cycle;
    logic   request_valid;

    int errors    = 0;
    int checks    = 0;
    int tests_run = 0;
    int seed      = 32'h3acb862b;

    synctimer_adjuster_calc #(
        .PERIOD_GAIN (6),
        .PHASE_GAIN  (6)
    ) DUT (
        .clk              (clk),
        .reset            (reset),
        .current_time     (current_time),
        .correct_renew    (correct_renew),
        .correct_time     (correct_time),
        .correct_valid    (correct_valid),
        .param_adjust_min (param_adjust_min),
        .param_adjust_max (param_adjust_max),
        .request_value    (request_value),
        .request_cycle    (request_cycle),
        .request_valid    (request_valid)
    );

    bind synctimer_adjuster_calc synctimer_adjuster_sva u_sva (
        .clk              (clk),
        .reset            (reset),
        .request_valid    (request_valid),
        .request_value    (request_value),
        .param_adjust_min (param_adjust_min),
        .param_adjust_max (param_adjust_max)
    );

    // --------------------
    // clock and local timer
    // --------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        current_time = 32'hffff_ff00; // wraps early in the run
        forever begin
            @(posedge clk);
            #1;
            current_time = current_time + time_t'(1);
        end
    end

    assign correct_time = current_time + time_offset;

    initial begin
        #(WATCH_CYCLES * 4);
        $display("timeout: tests did not finish within %0d cycles", WATCH_CYCLES);
        $display("Errors found");
        $finish;
    end

    // --------------------
    // compare tasks and reference rules
    // --------------------
    task automatic check_value(input error_t got, input error_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_cycle(input cycle_t got, input cycle_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // sum of two equal first estimates clamped to the limits
    function automatic error_t first_step_value(input int d, input limit_t lo, input limit_t hi);
        error_t sum;
        error_t lo_q;
        error_t hi_q;
        sum  = error_t'(2 * d) <<< ERROR_Q;
        lo_q = error_t'(lo) <<< ERROR_Q;
        hi_q = error_t'(hi) <<< ERROR_Q;
        if (sum < lo_q) begin
            return lo_q;
        end else if (sum > hi_q) begin
            return hi_q;
        end
        return sum;
    endfunction

    function automatic cycle_t next_cycle(input cycle_t est, input bit first, input int period);
        if (first) begin
            return cycle_t'(period) << CYCLE_Q;
        end
        return est - (est >> CYCLE_Q) + cycle_t'(period);
    endfunction

    // --------------------
    // stimulus
    // --------------------
    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // one strobe and then idle until the next one is due
    task automatic run_step(input time_t offset, input logic renew, input int period,
                            output error_t value);
        int  last;
        int  latency;
        bit  seen;
        last    = (period - 1 > 10) ? period - 1 : 10;
        seen    = 1'b0;
        latency = 0;
        value   = '0;
        @(posedge clk);
        #1;
        time_offset   = offset;
        correct_renew = renew;
        correct_valid = 1'b1;
        for (int i = 1; i <= last; i++) begin
            @(posedge clk);
            #1;
            if (i == 1) begin
                correct_valid = 1'b0;
                correct_renew = 1'b0;
            end
            if (request_valid && !seen && i <= 10) begin
                seen    = 1'b1;
                latency = i;
                value   = request_value;
            end
        end
        checks++;
        if (!seen) begin
            $display("no request_valid within 10 cycles of the strobe ending at %0t", $time);
            errors++;
        end else if (latency != 6) begin
            $display("FAIL %0t: request_valid %0d cycles after the strobe, expected 6",
                     $time, latency);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_reset_state();
        int start_errors;
        start_errors = errors;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            check_flag(request_valid, 1'b0, "request_valid after reset");
            check_value(request_value, '0, "request_value after reset");
            check_cycle(request_cycle, '0, "request_cycle after reset");
        end
        report_test("reset state", start_errors);
    endtask

    task automatic test_renew();
        int     start_errors;
        error_t value;
        start_errors     = errors;
        param_adjust_min = -LIMIT_WIDE;
        param_adjust_max = LIMIT_WIDE;
        for (int k = 0; k < RENEW_STEPS; k++) begin
            run_step(time_t'($random(seed)), 1'b1, ERR_PERIOD, value);
            check_value(value, '0, "renew adjustment");
        end
        report_test("renew", start_errors);
    endtask

    task automatic test_first_step();
        int     start_errors;
        int     d;
        error_t value;
        start_errors = errors;
        for (int k = 0; k < TRACK_STEPS; k++) begin
            run_step(time_t'($random(seed)), 1'b1, ERR_PERIOD, value);
            check_value(value, '0, "renew before first step");
            d = $random(seed) % 1000;
            run_step(time_t'(d), 1'b0, ERR_PERIOD, value);
            check_value(value, first_step_value(d, param_adjust_min, param_adjust_max),
                        "first step adjustment");
        end
        report_test("first step", start_errors);
    endtask

    task automatic test_limiter();
        int     start_errors;
        int     d;
        error_t value;
        start_errors     = errors;
        param_adjust_min = -LIMIT_NARROW;
        param_adjust_max = LIMIT_NARROW;
        for (int k = 0; k < LIMIT_STEPS; k++) begin
            d = 10000 + ($random(seed) & 32'hffff);
            if (k % 2 == 1) begin
                d = -d;
            end
            run_step(time_t'(d), 1'b1, ERR_PERIOD, value);
            check_value(value, '0, "renew before limited step");
            run_step(time_t'(d), 1'b0, ERR_PERIOD, value);
            check_value(value, first_step_value(d, param_adjust_min, param_adjust_max),
                        "limited adjustment");
        end
        report_test("limiter", start_errors);
    endtask

    task automatic test_cycle_estimate();
        int     start_errors;
        int     periods [6];
        cycle_t est;
        error_t value;
        start_errors = errors;
        periods      = '{CYCLE_P1, CYCLE_P1, CYCLE_P1, CYCLE_P2, CYCLE_P2, CYCLE_P2};
        est          = '0;
        apply_reset();
        for (int k = 0; k < 6; k++) begin
            run_step(time_t'($random(seed)), 1'b1, periods[k], value);
            check_value(value, '0, "renew during cycle test");
            if (k > 0) begin
                est = next_cycle(est, k == 1, periods[k-1]); // gap before this strobe
            end
            check_cycle(request_cycle, est, "cycle estimate");
        end
        report_test("cycle estimate", start_errors);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        reset            = 1'b1;
        time_offset      = '0;
        correct_valid    = 1'b0;
        correct_renew    = 1'b0;
        param_adjust_min = -LIMIT_WIDE;
        param_adjust_max = LIMIT_WIDE;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_renew();
        test_first_step();
        test_limiter();
        test_cycle_estimate();

        errors += DUT.u_sva.assert_failures;
        $display("summary: %0d tests, %0d checks, %0d errors (%0d from assertions)",
                 tests_run, checks, errors, DUT.u_sva.assert_failures);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: synctimer_adjust.f
logic/synctimer_pkg.sv
logic/lpf_update.sv
logic/cycle_estimator.sv
logic/error_estimator.sv
logic/synctimer_adjuster_calc.sv
dv/synctimer_adjuster_sva.sv
dv/synctimer_adjuster_tb.sv
